/* build.f */
+incdir+verilog
verilog/ctrl_pkg.sv
verilog/instr_decoder.sv
verilog/cond_eval.sv
verilog/sequencer.sv
verilog/ctrl_top.sv
testbench/tb_clock.sv
testbench/ctrl_assert.sv
testbench/tb_ctrl.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f build.f \
	--top-module tb_ctrl \
	--Mdir obj_dir \
	-o tb_ctrl_sim

./obj_dir/tb_ctrl_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"

/* testbench/ctrl_assert.sv */
// control unit assertions: strobe exclusivity, branch enable origin, fetch after reset
`include "ctrl_settings.svh"

module ctrl_assert (
	input logic                    clk,
	input logic                    reset,
	input logic [`CTRL_WORD_W-1:0] instr,
	input logic                    mem_we,
	input logic                    regwrite,
	input logic                    br_en,
	input logic                    pc_en
);

	timeunit 1ns;
	timeprecision 1ps;

	// read by the testbench at the end of the run
	int fail_count = 0;

	a_we_excl: assert property (@(posedge clk) disable iff (!reset)
		!(mem_we && regwrite))
		else begin
			$error("memory write and register write high in the same cycle");
			fail_count++;
		end

	// pc_en marks FETCH, so the next cycle is the first of the instruction
	a_br_origin: assert property (@(posedge clk) disable iff (!reset)
		(pc_en && instr[15:12] != `CTRL_OP_BCOND) |=> !br_en)
		else begin
			$error("branch enable raised by a word that is not a branch");
			fail_count++;
		end

	a_fetch_after_reset: assert property (@(posedge clk)
		$rose(reset) |-> pc_en)
		else begin
			$error("unit not in fetch in the first cycle after reset");
			fail_count++;
		end

endmodule

bind ctrl_top ctrl_assert u_assert (
	.clk      (clk),
	.reset    (reset),
	.instr    (instr),
	.mem_we   (mem_we),
	.regwrite (regwrite),
	.br_en    (br_en),
	.pc_en    (pc_en)
);

/* testbench/tb_clock.sv */
// testbench clock and reset: free-running clock, active-low reset held for a few edges
module tb_clock #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic reset
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// released on a rising edge, so the DUT still sees reset at that edge
	initial begin
		reset = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b1;
	end

endmodule

/* testbench/tb_ctrl.sv */
// control unit testbench: directed and random instructions checked cycle by cycle
`include "ctrl_settings.svh"

module tb_ctrl;

	timeunit 1ns;
	timeprecision 1ps;

	import ctrl_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int N_RANDOM   = 200;
	// rr, imm, load, store, branch, random
	localparam int N_INSTR    = 9 + 7 + 4 + 4 + 16 * 32 + N_RANDOM;

	logic        clk;
	logic        reset;
	instr_word_t instr;
	logic [4:0]  flags;
	logic        regwrite, flag_en, mem_we, load_sel, pc_en, pc_mux, br_en, use_imm_q;
	logic [3:0]  wa, ra1, ra2;
	logic [7:0]  aluop, imm8, br_disp;

	// expected vector per cycle holds strobes, wa, ra1, ra2, aluop, imm8 and br_disp
	logic [43:0] exp_q[$];
	int          n_checks;
	int          n_errors;
	int          test_base;
	logic [31:0] rng;
	instr_word_t prev_word;

	tb_clock #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(2)) u_clock (
		.clk   (clk),
		.reset (reset)
	);

	ctrl_top dut0 (
		.clk (clk), .reset (reset), .instr (instr), .flags (flags),
		.regwrite (regwrite), .flag_en (flag_en), .mem_we (mem_we),
		.load_sel (load_sel), .pc_en (pc_en), .pc_mux (pc_mux), .br_en (br_en),
		.use_imm_q (use_imm_q), .wa (wa), .ra1 (ra1), .ra2 (ra2),
		.aluop (aluop), .imm8 (imm8), .br_disp (br_disp)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	function automatic bit branch_taken(input logic [3:0] cond, input logic [4:0] f);
		logic c, l, ff, z, n;
		c  = f[`CTRL_FLAG_C];
		l  = f[`CTRL_FLAG_L];
		ff = f[`CTRL_FLAG_F];
		z  = f[`CTRL_FLAG_Z];
		n  = f[`CTRL_FLAG_N];
		case (cond)
			4'b0000: return z;
			4'b0001: return !z;
			4'b0010: return c;
			4'b0011: return !c;
			4'b0100: return l;
			4'b0101: return !l;
			4'b0110: return n;
			4'b0111: return !n;
			4'b1000: return ff;
			4'b1001: return !ff;
			4'b1010: return !l && !z;
			4'b1011: return l && z;
			4'b1100: return z && !n;
			4'b1101: return z && n;
			4'b1110: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic int instr_cycles(input instr_word_t w);
		if (w[15:12] == `CTRL_OP_MEM && w[7:4] == `CTRL_FN_LOAD)
			return 3;
		return 2;
	endfunction

	// expected outputs for a word at a cycle offset; offset 0 is FETCH
	function automatic logic [43:0] ref_ctrl(input instr_word_t w, input logic [4:0] f,
		input int offset);
		logic [3:0] op, fn;
		bit rr_alu, imm_alu, is_cmp, ld, st, br;
		logic rw, fe, we, ls, pe, pm, be;
		logic [7:0] disp;
		op      = w[15:12];
		fn      = w[7:4];
		rr_alu  = (op == `CTRL_OP_RR) && (fn inside {`CTRL_FN_AND, `CTRL_FN_OR,
			`CTRL_FN_XOR, `CTRL_FN_ADD, `CTRL_FN_ADDU, `CTRL_FN_ADDC, `CTRL_FN_SUB,
			`CTRL_FN_CMP, `CTRL_FN_MOV});
		imm_alu = op inside {`CTRL_OP_ANDI, `CTRL_OP_ORI, `CTRL_OP_ADDI,
			`CTRL_OP_SUBI, `CTRL_OP_CMPI, `CTRL_OP_MOVI, `CTRL_OP_LUI};
		is_cmp  = (rr_alu && fn == `CTRL_FN_CMP) || op == `CTRL_OP_CMPI;
		ld      = op == `CTRL_OP_MEM && fn == `CTRL_FN_LOAD;
		st      = op == `CTRL_OP_MEM && fn == `CTRL_FN_STOR;
		br      = op == `CTRL_OP_BCOND;
		rw   = 1'b0;
		fe   = 1'b0;
		we   = 1'b0;
		ls   = 1'b0;
		pe   = 1'b0;
		pm   = 1'b1;
		be   = 1'b0;
		disp = 8'h00;
		if (offset == 0) begin
			pe = 1'b1;
		end else if (ld) begin
			pm = 1'b0;
			if (offset == 2) begin
				rw = 1'b1;
				ls = 1'b1;
			end
		end else if (st) begin
			we = 1'b1;
			pm = 1'b0;
		end else if (br) begin
			be   = branch_taken(w[11:8], f);
			disp = w[7:0];
		end else begin
			// unknown words fall here with both low
			rw = (rr_alu || imm_alu) && !is_cmp;
			fe = rr_alu || imm_alu;
		end
		return {rw, fe, we, ls, pe, pm, be, imm_alu, w[11:8], w[11:8], w[3:0],
			op, fn, w[7:0], disp};
	endfunction

	task automatic check_value(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("mismatch at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic run_instr(input instr_word_t w, input logic [4:0] f);
		int len;
		int i;
		len = instr_cycles(w);
		@(negedge clk);
		instr = w;
		flags = f;
		exp_q.push_back(ref_ctrl(prev_word, f, 0));
		for (i = 1; i < len; i++)
			exp_q.push_back(ref_ctrl(w, f, i));
		prev_word = w;
		repeat (len - 1) @(negedge clk);
	endtask

	// returns before the next FETCH cycle ends, so no stale word is latched
	task automatic end_test(input string name);
		while (exp_q.size() != 0) @(posedge clk);
		$display("test %s done: %0d errors", name, n_errors - test_base);
		test_base = n_errors;
	endtask

	function automatic instr_word_t rand_word();
		logic [31:0] r;
		instr_word_t w;
		r = next_rand();
		w = r[15:0];
		// push some words onto the memory codes
		if (r[17:16] == 2'b00) begin
			w.rr.opcode = `CTRL_OP_MEM;
			w.rr.func   = r[18] ? `CTRL_FN_LOAD : `CTRL_FN_STOR;
		end
		return w;
	endfunction

	// sampled mid low phase, well after outputs settle
	initial begin
		logic [43:0] e;
		logic [43:0] got;
		@(posedge reset);
		forever begin
			@(negedge clk);
			#10;
			if (exp_q.size() != 0) begin
				e   = exp_q.pop_front();
				got = {regwrite, flag_en, mem_we, load_sel, pc_en, pc_mux, br_en,
					use_imm_q, wa, ra1, ra2, aluop, imm8, br_disp};
				check_value("strobes", 64'(got[43:36]), 64'(e[43:36]));
				check_value("wa", 64'(got[35:32]), 64'(e[35:32]));
				check_value("ra1", 64'(got[31:28]), 64'(e[31:28]));
				check_value("ra2", 64'(got[27:24]), 64'(e[27:24]));
				check_value("aluop", 64'(got[23:16]), 64'(e[23:16]));
				check_value("imm8", 64'(got[15:8]), 64'(e[15:8]));
				check_value("br_disp", 64'(got[7:0]), 64'(e[7:0]));
			end
		end
	end

	initial begin
		#((N_INSTR * 3 + 50) * CLK_PERIOD);
		$display("timeout: the tests did not finish in the expected time");
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		logic [3:0]  rr_funcs[9];
		logic [3:0]  imm_ops[7];
		logic [31:0] r;
		instr_word_t w;
		int          i;
		int          k;
		rr_funcs = '{`CTRL_FN_AND, `CTRL_FN_OR, `CTRL_FN_XOR, `CTRL_FN_ADD,
			`CTRL_FN_ADDU, `CTRL_FN_ADDC, `CTRL_FN_SUB, `CTRL_FN_CMP, `CTRL_FN_MOV};
		imm_ops  = '{`CTRL_OP_ANDI, `CTRL_OP_ORI, `CTRL_OP_ADDI, `CTRL_OP_SUBI,
			`CTRL_OP_CMPI, `CTRL_OP_MOVI, `CTRL_OP_LUI};
		rng       = 32'h34817e17;
		instr     = '0;
		flags     = '0;
		prev_word = '0;
		n_checks  = 0;
		n_errors  = 0;
		test_base = 0;
		@(posedge reset);

		for (i = 0; i < 9; i++) begin
			r = next_rand();
			w = {`CTRL_OP_RR, r[3:0], rr_funcs[i], r[7:4]};
			run_instr(w, r[12:8]);
		end
		end_test("register ops");

		for (i = 0; i < 7; i++) begin
			r = next_rand();
			w = {imm_ops[i], r[3:0], r[11:4]};
			run_instr(w, r[16:12]);
		end
		end_test("immediate ops");

		for (i = 0; i < 4; i++) begin
			r = next_rand();
			w = {`CTRL_OP_MEM, r[3:0], `CTRL_FN_LOAD, r[7:4]};
			run_instr(w, r[12:8]);
		end
		end_test("load");

		for (i = 0; i < 4; i++) begin
			r = next_rand();
			w = {`CTRL_OP_MEM, r[3:0], `CTRL_FN_STOR, r[7:4]};
			run_instr(w, r[12:8]);
		end
		end_test("store");

		// each condition sees every flag vector in a randomly scrambled order
		for (i = 0; i < 16; i++) begin
			r = next_rand();
			for (k = 0; k < 32; k++) begin
				w = {`CTRL_OP_BCOND, 4'(i), r[7:0] ^ 8'(k)};
				run_instr(w, r[12:8] ^ 5'(k));
			end
		end
		end_test("branch");

		for (i = 0; i < N_RANDOM; i++) begin
			r = next_rand();
			run_instr(rand_word(), r[4:0]);
		end
		end_test("random stream");

		n_errors = n_errors + dut0.u_assert.fail_count;
		$display("6 tests, %0d checks, %0d errors, %0d assertion failures",
			n_checks, n_errors, dut0.u_assert.fail_count);
		if (n_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* verilog/cond_eval.sv */
// branch condition evaluator: tests a condition code against the processor flags
`include "ctrl_settings.svh"

module cond_eval (
	input  logic [`CTRL_COND_W-1:0] cond,
	input  logic [`CTRL_FLAG_W-1:0] flags,
	output logic                    taken
);

	logic flag_c;
	logic flag_l;
	logic flag_f;
	logic flag_z;
	logic flag_n;

	assign flag_c = flags[`CTRL_FLAG_C];
	assign flag_l = flags[`CTRL_FLAG_L];
	assign flag_f = flags[`CTRL_FLAG_F];
	assign flag_z = flags[`CTRL_FLAG_Z];
	assign flag_n = flags[`CTRL_FLAG_N];

	always_comb begin
		case (cond)
			`CTRL_CC_EQ: taken = flag_z;
			`CTRL_CC_NE: taken = ~flag_z;
			`CTRL_CC_CS: taken = flag_c;
			`CTRL_CC_CC: taken = ~flag_c;
			`CTRL_CC_HI: taken = flag_l;
			`CTRL_CC_LS: taken = ~flag_l;
			`CTRL_CC_GT: taken = flag_n;
			`CTRL_CC_LE: taken = ~flag_n;
			`CTRL_CC_FS: taken = flag_f;
			// F clear, not F set
			`CTRL_CC_FC: taken = ~flag_f;
			`CTRL_CC_LO: taken = ~flag_l & ~flag_z;
			`CTRL_CC_HS: taken = flag_l & flag_z;
			`CTRL_CC_LT: taken = flag_z & ~flag_n;
			`CTRL_CC_GE: taken = flag_z & flag_n;
			`CTRL_CC_UC: taken = 1'b1;
			// NV never branches
			default:     taken = 1'b0;
		endcase
	end

endmodule

/* verilog/ctrl_pkg.sv */
// control unit package: the instruction word and its two field layouts
`include "ctrl_settings.svh"

package ctrl_pkg;

	// one 16-bit word, read as register form or as immediate/branch form
	typedef union packed {
		// register-register and memory instructions
		struct packed {
			logic [`CTRL_OP_W-1:0]   opcode;
			logic [`CTRL_REG_W-1:0]  rdest;
			logic [`CTRL_FUNC_W-1:0] func;
			logic [`CTRL_REG_W-1:0]  rsrc;
		} rr;
		// immediate ALU and branch instructions
		// rdest doubles as the condition code, imm8 as the displacement
		struct packed {
			logic [`CTRL_OP_W-1:0]  opcode;
			logic [`CTRL_REG_W-1:0] rdest;
			logic [`CTRL_IMM_W-1:0] imm8;
		} ri;
	} instr_word_t;

endpackage

/* verilog/ctrl_settings.svh */
// control unit settings: field widths, opcodes, function codes, conditions, flags, states
`ifndef CTRL_SETTINGS_SVH
`define CTRL_SETTINGS_SVH

// field widths
`define CTRL_WORD_W   16
`define CTRL_OP_W     4
`define CTRL_REG_W    4
`define CTRL_FUNC_W   4
`define CTRL_IMM_W    8
`define CTRL_ALUOP_W  8
`define CTRL_COND_W   4
`define CTRL_FLAG_W   5

// flag vector bit positions
`define CTRL_FLAG_C   0
`define CTRL_FLAG_L   1
`define CTRL_FLAG_F   2
`define CTRL_FLAG_Z   3
`define CTRL_FLAG_N   4

// major opcodes
`define CTRL_OP_RR    4'b0000
`define CTRL_OP_MEM   4'b0100
`define CTRL_OP_BCOND 4'b1100

// immediate opcodes
`define CTRL_OP_ANDI  4'b0001
`define CTRL_OP_ORI   4'b0010
`define CTRL_OP_ADDI  4'b0101
`define CTRL_OP_SUBI  4'b1001
`define CTRL_OP_CMPI  4'b1011
`define CTRL_OP_MOVI  4'b1101
`define CTRL_OP_LUI   4'b1111

// register-register function codes
`define CTRL_FN_AND   4'b0001
`define CTRL_FN_OR    4'b0010
`define CTRL_FN_XOR   4'b0011
`define CTRL_FN_ADD   4'b0101
`define CTRL_FN_ADDU  4'b0110
`define CTRL_FN_ADDC  4'b0111
`define CTRL_FN_SUB   4'b1001
`define CTRL_FN_CMP   4'b1011
`define CTRL_FN_MOV   4'b1101

// memory function codes
`define CTRL_FN_LOAD  4'b0000
`define CTRL_FN_STOR  4'b0100

// branch condition codes
`define CTRL_CC_EQ    4'b0000
`define CTRL_CC_NE    4'b0001
`define CTRL_CC_CS    4'b0010
`define CTRL_CC_CC    4'b0011
`define CTRL_CC_HI    4'b0100
`define CTRL_CC_LS    4'b0101
`define CTRL_CC_GT    4'b0110
`define CTRL_CC_LE    4'b0111
`define CTRL_CC_FS    4'b1000
`define CTRL_CC_FC    4'b1001
`define CTRL_CC_LO    4'b1010
`define CTRL_CC_HS    4'b1011
`define CTRL_CC_LT    4'b1100
`define CTRL_CC_GE    4'b1101
`define CTRL_CC_UC    4'b1110
`define CTRL_CC_NV    4'b1111

// sequencer states
`define CTRL_ST_W        3
`define CTRL_ST_FETCH    3'd0
`define CTRL_ST_EXEC     3'd1
`define CTRL_ST_LD_ADDR  3'd2
`define CTRL_ST_LD_WB    3'd3
`define CTRL_ST_ST_WRITE 3'd4
`define CTRL_ST_BR_EVAL  3'd5

`endif

/* verilog/ctrl_top.sv */
// control unit top: instruction decoder feeding the multicycle sequencer
`include "ctrl_settings.svh"

module ctrl_top (
	input  logic                      clk,
	input  logic                      reset,
	input  ctrl_pkg::instr_word_t     instr,
	input  logic [`CTRL_FLAG_W-1:0]   flags,
	output logic                      regwrite,
	output logic                      flag_en,
	output logic                      mem_we,
	output logic                      load_sel,
	output logic                      pc_en,
	output logic                      pc_mux,
	output logic                      br_en,
	output logic                      use_imm_q,
	output logic [`CTRL_REG_W-1:0]    wa,
	output logic [`CTRL_REG_W-1:0]    ra1,
	output logic [`CTRL_REG_W-1:0]    ra2,
	output logic [`CTRL_ALUOP_W-1:0]  aluop,
	output logic [`CTRL_IMM_W-1:0]    imm8,
	output logic [`CTRL_IMM_W-1:0]    br_disp
);

	logic                     is_alu;
	logic                     is_load;
	logic                     is_store;
	logic                     is_branch;
	logic                     use_imm;
	logic                     writes_reg;
	logic [`CTRL_ALUOP_W-1:0] alu_op;

	instr_decoder u_dec (
		.instr      (instr),
		.is_alu     (is_alu),
		.is_load    (is_load),
		.is_store   (is_store),
		.is_branch  (is_branch),
		.use_imm    (use_imm),
		.writes_reg (writes_reg),
		.alu_op     (alu_op)
	);

	sequencer u_seq (
		.clk        (clk),
		.reset      (reset),
		.instr      (instr),
		.flags      (flags),
		.is_alu     (is_alu),
		.is_load    (is_load),
		.is_store   (is_store),
		.is_branch  (is_branch),
		.use_imm    (use_imm),
		.writes_reg (writes_reg),
		.alu_op     (alu_op),
		.regwrite   (regwrite),
		.flag_en    (flag_en),
		.mem_we     (mem_we),
		.load_sel   (load_sel),
		.pc_en      (pc_en),
		.pc_mux     (pc_mux),
		.br_en      (br_en),
		.use_imm_q  (use_imm_q),
		.wa         (wa),
		.ra1        (ra1),
		.ra2        (ra2),
		.aluop      (aluop),
		.imm8       (imm8),
		.br_disp    (br_disp)
	);

endmodule

/* verilog/instr_decoder.sv */
// instruction decoder: sorts a word into its class and derives ALU op and write permission
`include "ctrl_settings.svh"

module instr_decoder (
	input  ctrl_pkg::instr_word_t      instr,
	output logic                       is_alu,
	output logic                       is_load,
	output logic                       is_store,
	output logic                       is_branch,
	output logic                       use_imm,
	output logic                       writes_reg,
	output logic [`CTRL_ALUOP_W-1:0]   alu_op
);

	logic [`CTRL_OP_W-1:0]   opcode;
	logic [`CTRL_FUNC_W-1:0] func;
	logic                    rr_valid;
	logic                    imm_valid;
	logic                    is_compare;

	assign opcode = instr.rr.opcode;
	assign func   = instr.rr.func;

	// register-register class: opcode 0 with a known function code
	always_comb begin
		rr_valid = 1'b0;
		if (opcode == `CTRL_OP_RR) begin
			case (func)
				`CTRL_FN_AND, `CTRL_FN_OR, `CTRL_FN_XOR,
				`CTRL_FN_ADD, `CTRL_FN_ADDU, `CTRL_FN_ADDC,
				`CTRL_FN_SUB, `CTRL_FN_CMP, `CTRL_FN_MOV: rr_valid = 1'b1;
				default:                                  rr_valid = 1'b0;
			endcase
		end
	end

	// immediate class is identified by opcode alone
	always_comb begin
		case (opcode)
			`CTRL_OP_ANDI, `CTRL_OP_ORI, `CTRL_OP_ADDI, `CTRL_OP_SUBI,
			`CTRL_OP_CMPI, `CTRL_OP_MOVI, `CTRL_OP_LUI: imm_valid = 1'b1;
			default:                                    imm_valid = 1'b0;
		endcase
	end

	// compares only set flags
	assign is_compare = (rr_valid && func == `CTRL_FN_CMP) ||
	                    (opcode == `CTRL_OP_CMPI);

	assign is_alu     = rr_valid | imm_valid;
	assign use_imm    = imm_valid;
	assign writes_reg = is_alu & ~is_compare;

	assign is_load   = (opcode == `CTRL_OP_MEM) && (func == `CTRL_FN_LOAD);
	assign is_store  = (opcode == `CTRL_OP_MEM) && (func == `CTRL_FN_STOR);
	assign is_branch = (opcode == `CTRL_OP_BCOND);

	// for immediates the low nibble is the top of imm8, as the ALU expects
	assign alu_op = {opcode, func};

endmodule

/* verilog/sequencer.sv */
// control sequencer: state and instruction registers plus per-state datapath strobes
`include "ctrl_settings.svh"

module sequencer (
	input  logic                      clk,
	input  logic                      reset,
	input  ctrl_pkg::instr_word_t     instr,
	input  logic [`CTRL_FLAG_W-1:0]   flags,
	input  logic                      is_alu,
	input  logic                      is_load,
	input  logic                      is_store,
	input  logic                      is_branch,
	input  logic                      use_imm,
	input  logic                      writes_reg,
	input  logic [`CTRL_ALUOP_W-1:0]  alu_op,
	output logic                      regwrite,
	output logic                      flag_en,
	output logic                      mem_we,
	output logic                      load_sel,
	output logic                      pc_en,
	output logic                      pc_mux,
	output logic                      br_en,
	output logic                      use_imm_q,
	output logic [`CTRL_REG_W-1:0]    wa,
	output logic [`CTRL_REG_W-1:0]    ra1,
	output logic [`CTRL_REG_W-1:0]    ra2,
	output logic [`CTRL_ALUOP_W-1:0]  aluop,
	output logic [`CTRL_IMM_W-1:0]    imm8,
	output logic [`CTRL_IMM_W-1:0]    br_disp
);

	import ctrl_pkg::*;

	logic [`CTRL_ST_W-1:0]    state;
	logic [`CTRL_ST_W-1:0]    next_state;
	instr_word_t              ir;
	logic [`CTRL_ALUOP_W-1:0] alu_op_q;
	logic                     alu_q;
	logic                     writes_q;
	logic                     taken;

	// condition comes from the latched word, flags are live
	cond_eval u_cond (
		.cond  (ir.ri.rdest),
		.flags (flags),
		.taken (taken)
	);

	// state register
	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= `CTRL_ST_FETCH;
		end else begin
			state <= next_state;
		end
	end

	// instruction and decode latch, loaded only on the fetch edge
	always_ff @(posedge clk) begin
		if (!reset) begin
			ir        <= '0;
			alu_op_q  <= '0;
			alu_q     <= 1'b0;
			writes_q  <= 1'b0;
			use_imm_q <= 1'b0;
		end else if (state == `CTRL_ST_FETCH) begin
			ir        <= instr;
			alu_op_q  <= alu_op;
			alu_q     <= is_alu;
			writes_q  <= writes_reg;
			use_imm_q <= use_imm;
		end
	end

	// next state
	always_comb begin
		next_state = `CTRL_ST_FETCH;
		case (state)
			`CTRL_ST_FETCH: begin
				// ALU ops and unknown words both go through EXEC
				if (is_load) begin
					next_state = `CTRL_ST_LD_ADDR;
				end else if (is_store) begin
					next_state = `CTRL_ST_ST_WRITE;
				end else if (is_branch) begin
					next_state = `CTRL_ST_BR_EVAL;
				end else begin
					next_state = `CTRL_ST_EXEC;
				end
			end
			`CTRL_ST_LD_ADDR: next_state = `CTRL_ST_LD_WB;
			// EXEC, LD_WB, ST_WRITE and BR_EVAL all end the instruction
			default:          next_state = `CTRL_ST_FETCH;
		endcase
	end

	// per-state strobes
	always_comb begin
		regwrite = 1'b0;
		flag_en  = 1'b0;
		mem_we   = 1'b0;
		load_sel = 1'b0;
		pc_en    = 1'b0;
		pc_mux   = 1'b1;
		br_en    = 1'b0;
		br_disp  = '0;
		case (state)
			`CTRL_ST_FETCH: begin
				pc_en = 1'b1;
			end
			`CTRL_ST_EXEC: begin
				// no-ops leave both low
				regwrite = writes_q;
				flag_en  = alu_q;
			end
			`CTRL_ST_LD_ADDR: begin
				// ra2 drives the memory address
				pc_mux = 1'b0;
			end
			`CTRL_ST_LD_WB: begin
				regwrite = 1'b1;
				load_sel = 1'b1;
				pc_mux   = 1'b0;
			end
			`CTRL_ST_ST_WRITE: begin
				mem_we = 1'b1;
				pc_mux = 1'b0;
			end
			`CTRL_ST_BR_EVAL: begin
				br_en   = taken;
				br_disp = ir.ri.imm8;
			end
			default: begin
				pc_en = 1'b0;
			end
		endcase
	end

	// operand fields stay on the latched word until the next fetch
	assign wa    = ir.rr.rdest;
	assign ra1   = ir.rr.rdest;
	assign ra2   = ir.rr.rsrc;
	assign aluop = alu_op_q;
	assign imm8  = ir.ri.imm8;

endmodule
